// File: logic/excision_sample_pkg.sv
`default_nettype none

package excision_sample_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // lane block geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int LANES    = 8;
  // complex mode pairs even (I) and odd (Q) lanes
  localparam int PAIRS    = LANES / 2;
  localparam int SAMPLE_W = 16;
  localparam int MAG_W    = 16;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [MAG_W-1:0]    mag_t;
  // one bit per lane, 1 keeps the lane
  typedef logic        [LANES-1:0]    keep_t;

  typedef struct packed {
    sample_t [LANES-1:0] lane;
  } sample_blk_t;

  // complex mode fills entries 0 to PAIRS-1, upper entries stay zero
  typedef struct packed {
    mag_t [LANES-1:0] lane;
  } mag_blk_t;

endpackage

`default_nettype wire

// File: logic/excision_ctrl_pkg.sv
`default_nettype none

package excision_ctrl_pkg;

  // mode level, 1 reads the block as real samples
  localparam logic MODE_REAL = 1'b1;

  typedef struct packed {
    logic valid;
    logic last;
    logic mode;
  } ctrl_t;

  localparam int THR_W = 16;

  typedef logic [THR_W-1:0] thresh_t;

  ////////////////////////////////////////////////////////////////////////////
  // estimator constants
  ////////////////////////////////////////////////////////////////////////////

  // keeps every lane until the first frame closes
  localparam thresh_t THR_INIT    = '1;
  localparam int      THR_MULT    = 3;
  // log2 of 16 nominal blocks times 8 entries
  localparam int      FRAME_SHIFT = 7;
  localparam int      ACC_W       = 24;

endpackage

`default_nettype wire

// File: logic/magnitude_stage.sv
`default_nettype none

module magnitude_stage
  import excision_sample_pkg::*;
  import excision_ctrl_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  ctrl_t       i_ctrl,
  input  sample_blk_t i_data,
  output ctrl_t       o_ctrl,
  output mag_blk_t    o_mag
);

  mag_t [LANES-1:0] lane_abs;
  mag_blk_t         mag_d;

  // larger component plus half the smaller, at most 49152
  function automatic mag_t cplx_mod(input mag_t a, input mag_t b);
    if (a >= b) begin
      return a + (b >> 1);
    end
    return b + (a >> 1);
  endfunction

  // negative full scale wraps to 0x8000, which is 32768 unsigned
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (i_data.lane[i][SAMPLE_W-1]) begin
        lane_abs[i] = mag_t'(-i_data.lane[i]);
      end else begin
        lane_abs[i] = mag_t'(i_data.lane[i]);
      end
    end
  end

  always_comb begin
    mag_d = '0;
    if (i_ctrl.mode == MODE_REAL) begin
      mag_d.lane = lane_abs;
    end else begin
      for (int p = 0; p < PAIRS; p++) begin
        mag_d.lane[p] = cplx_mod(lane_abs[2*p], lane_abs[2*p+1]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ctrl <= '0;
    end else begin
      o_ctrl <= i_ctrl;
    end
  end

  // magnitudes only move with a valid block
  always_ff @(posedge clk) begin
    if (i_ctrl.valid) begin
      o_mag <= mag_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/threshold_estimator.sv
`default_nettype none

module threshold_estimator
  import excision_sample_pkg::*;
  import excision_ctrl_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  input  ctrl_t    i_ctrl,
  input  mag_blk_t i_mag,
  output thresh_t  o_thresh
);

  logic [ACC_W-1:0] acc_q;
  logic [ACC_W-1:0] blk_sum;
  logic [ACC_W-1:0] frame_sum;
  logic [ACC_W+1:0] scaled;
  logic [ACC_W+1:0] mean;
  thresh_t          thr_next;

  // complex entries count twice so both modes weigh eight per block
  always_comb begin
    blk_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      blk_sum = blk_sum + ACC_W'(i_mag.lane[i]);
    end
    if (i_ctrl.mode != MODE_REAL) begin
      blk_sum = blk_sum << 1;
    end
  end

  // the closing block is part of its own frame sum
  assign frame_sum = acc_q + blk_sum;
  assign scaled    = (ACC_W+2)'(frame_sum) * (ACC_W+2)'(THR_MULT);
  assign mean      = scaled >> FRAME_SHIFT;

  // saturate to all ones on overflow
  assign thr_next = (|mean[ACC_W+1:THR_W]) ? '1 : thresh_t'(mean);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q    <= '0;
      o_thresh <= THR_INIT;
    end else if (i_ctrl.valid) begin
      if (i_ctrl.last) begin
        o_thresh <= thr_next;
        acc_q    <= '0;
      end else begin
        acc_q    <= frame_sum;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/threshold_compare.sv
`default_nettype none

module threshold_compare
  import excision_sample_pkg::*;
  import excision_ctrl_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  input  ctrl_t    i_ctrl,
  input  mag_blk_t i_mag,
  input  thresh_t  i_thresh,
  output ctrl_t    o_ctrl,
  output keep_t    o_keep
);

  keep_t below;
  keep_t keep_d;

  // entry i at or under the threshold survives
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      below[i] = (i_mag.lane[i] <= i_thresh);
    end
  end

  // pair verdict covers both I and Q lanes
  always_comb begin
    keep_d = below;
    if (i_ctrl.mode != MODE_REAL) begin
      for (int p = 0; p < PAIRS; p++) begin
        keep_d[2*p]   = below[p];
        keep_d[2*p+1] = below[p];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ctrl <= '0;
    end else begin
      o_ctrl <= i_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (i_ctrl.valid) begin
      o_keep <= keep_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/sample_align.sv
`default_nettype none

module sample_align
  import excision_sample_pkg::*;
#(
  parameter int DEPTH = 2
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         i_valid,
  input  sample_blk_t i_data,
  output sample_blk_t o_data
);

  sample_blk_t stage_q [DEPTH];

  // head loads on valid, the rest shift every clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      if (i_valid) begin
        stage_q[0] <= i_data;
      end
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign o_data = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// File: logic/blanking_stage.sv
`default_nettype none

module blanking_stage
  import excision_sample_pkg::*;
  import excision_ctrl_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  ctrl_t       i_ctrl,
  input  keep_t       i_keep,
  input  sample_blk_t i_data,
  output logic        o_valid,
  output logic        o_last,
  output sample_blk_t o_data,
  output keep_t       o_keep
);

  sample_blk_t blanked;

  // flagged lanes forced to zero
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      blanked.lane[i] = i_keep[i] ? i_data.lane[i] : sample_t'(0);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
      o_data  <= '0;
      o_keep  <= '0;
    end else begin
      o_valid <= i_ctrl.valid;
      // last only shows together with valid
      o_last  <= i_ctrl.valid & i_ctrl.last;
      if (i_ctrl.valid) begin
        o_data <= blanked;
        o_keep <= i_keep;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/excision_top.sv
`default_nettype none

module excision_top
  import excision_sample_pkg::*;
  import excision_ctrl_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  ctrl_t       i_ctrl,
  input  sample_blk_t i_data,
  output logic        o_valid,
  output logic        o_last,
  output sample_blk_t o_data,
  output keep_t       o_keep,
  output thresh_t     o_thresh
);

  ////////////////////////////////////////////////////////////////////////////
  // stage wires
  ////////////////////////////////////////////////////////////////////////////

  ctrl_t       mag_ctrl;
  mag_blk_t    mag_blk;
  ctrl_t       cmp_ctrl;
  keep_t       cmp_keep;
  sample_blk_t data_dly;

  magnitude_stage u_magnitude (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_ctrl (i_ctrl),
    .i_data (i_data),
    .o_ctrl (mag_ctrl),
    .o_mag  (mag_blk)
  );

  // threshold feeds compare and is also visible outside
  threshold_estimator u_estimator (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_ctrl   (mag_ctrl),
    .i_mag    (mag_blk),
    .o_thresh (o_thresh)
  );

  threshold_compare u_compare (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_ctrl   (mag_ctrl),
    .i_mag    (mag_blk),
    .i_thresh (o_thresh),
    .o_ctrl   (cmp_ctrl),
    .o_keep   (cmp_keep)
  );

  // raw samples ride beside magnitude and compare
  sample_align #(
    .DEPTH (2)
  ) u_align (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_ctrl.valid),
    .i_data  (i_data),
    .o_data  (data_dly)
  );

  blanking_stage u_blanking (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_ctrl  (cmp_ctrl),
    .i_keep  (cmp_keep),
    .i_data  (data_dly),
    .o_valid (o_valid),
    .o_last  (o_last),
    .o_data  (o_data),
    .o_keep  (o_keep)
  );

endmodule

`default_nettype wire

// File: testbench/tb_excision.sv
`default_nettype none

module tb_excision
  import excision_sample_pkg::*;
  import excision_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // about 8 frames of 16 blocks plus gaps is near 200 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int PIPE_LAT       = 3;
  localparam int SEL_REAL       = 0;
  localparam int SEL_CPLX       = 1;
  localparam int SEL_MIX        = 2;

  typedef struct packed {
    sample_blk_t data;
    keep_t       keep;
    logic        last;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst_n;
  ctrl_t       i_ctrl;
  sample_blk_t i_data;
  logic        o_valid;
  logic        o_last;
  sample_blk_t o_data;
  keep_t       o_keep;
  thresh_t     o_thresh;

  expect_t     exp_q[$];
  expect_t     exp_blk;
  thresh_t     thr_hist[$];
  thresh_t     model_thr;
  int          frame_acc;
  logic [31:0] rnd_state;
  logic        run_active = 1'b0;
  int          blocks_checked = 0;
  int          cycle_cnt = 0;
  int          value_errs = 0;
  int          latency_errs = 0;
  int          flow_errs = 0;

  excision_top excision_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_ctrl   (i_ctrl),
    .i_data   (i_data),
    .o_valid  (o_valid),
    .o_last   (o_last),
    .o_data   (o_data),
    .o_keep   (o_keep),
    .o_thresh (o_thresh)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_block(input ctrl_t c, input sample_blk_t d);
    int      mag [LANES];
    int      blk_sum;
    int      cmod;
    int      scaled;
    expect_t e;
    blk_sum = 0;
    e.keep  = '0;
    for (int i = 0; i < LANES; i++) begin
      mag[i] = int'($signed(d.lane[i]));
      if (mag[i] < 0) begin
        mag[i] = -mag[i];
      end
    end
    if (c.mode == MODE_REAL) begin
      for (int i = 0; i < LANES; i++) begin
        e.keep[i] = (mag[i] <= int'(model_thr));
        blk_sum += mag[i];
      end
    end else begin
      for (int p = 0; p < PAIRS; p++) begin
        if (mag[2*p] >= mag[2*p+1]) begin
          cmod = mag[2*p] + mag[2*p+1] / 2;
        end else begin
          cmod = mag[2*p+1] + mag[2*p] / 2;
        end
        e.keep[2*p]   = (cmod <= int'(model_thr));
        e.keep[2*p+1] = e.keep[2*p];
        // pair counts twice toward the frame sum
        blk_sum += 2 * cmod;
      end
    end
    for (int i = 0; i < LANES; i++) begin
      e.data.lane[i] = e.keep[i] ? d.lane[i] : sample_t'(0);
    end
    e.last = c.last;
    exp_q.push_back(e);
    frame_acc += blk_sum;
    // closing block was judged above, new threshold applies afterwards
    if (c.last) begin
      scaled    = (THR_MULT * frame_acc) >> FRAME_SHIFT;
      model_thr = (scaled > 65535) ? '1 : thresh_t'(scaled);
      frame_acc = 0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic make_block(input bit burst, output sample_blk_t d);
    int m;
    for (int i = 0; i < LANES; i++) begin
      rnd_state = xorshift32(rnd_state);
      // interference on about one lane in eight
      if (burst || rnd_state[31:29] == 3'b000) begin
        m = 24576 + int'(rnd_state[12:0]);
      end else begin
        m = int'(rnd_state[10:0]);
      end
      d.lane[i] = rnd_state[28] ? sample_t'(-m) : sample_t'(m);
    end
  endtask

  task automatic drive_cycle(input ctrl_t c, input sample_blk_t d);
    @(posedge clk);
    i_ctrl <= c;
    i_data <= d;
    run_active = 1'b1;
    if (c.valid) begin
      model_block(c, d);
    end
    // o_thresh lags the model by two edges
    thr_hist.push_back(model_thr);
    thr_hist.delete(0);
  endtask

  task automatic send_frame(input int n_blk, input int mode_sel, input bit burst,
                            input bit gaps, input int neg_blk);
    ctrl_t       c;
    sample_blk_t d;
    int          n_gap;
    for (int b = 0; b < n_blk; b++) begin
      n_gap = 0;
      if (gaps) begin
        rnd_state = xorshift32(rnd_state);
        n_gap     = int'(rnd_state[1:0]);
      end
      // idle cycles still carry random data
      for (int g = 0; g < n_gap; g++) begin
        make_block(1'b0, d);
        drive_cycle('0, d);
      end
      make_block(burst, d);
      c.valid = 1'b1;
      c.last  = (b == n_blk - 1);
      if (mode_sel == SEL_MIX) begin
        rnd_state = xorshift32(rnd_state);
        c.mode    = rnd_state[7];
      end else begin
        c.mode = (mode_sel == SEL_REAL);
      end
      if (b == neg_blk) begin
        d.lane[3] = 16'sh8000;
      end
      drive_cycle(c, d);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////////////////////

  valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid == $past(i_ctrl.valid, PIPE_LAT))
    else begin
      latency_errs++;
      $display("ERROR %0t: o_valid does not follow input valid by %0d cycles",
               $time, PIPE_LAT);
    end

  last_latency: assert property (@(posedge clk) disable iff (!rst_n)
    o_last == $past(i_ctrl.valid && i_ctrl.last, PIPE_LAT))
    else begin
      latency_errs++;
      $display("ERROR %0t: o_last is not aligned with the closing block", $time);
    end

  always @(negedge clk) begin
    if (run_active) begin
      thresh_check: assert (o_thresh == thr_hist[0])
        else begin
          value_errs++;
          $display("ERROR %0t: o_thresh %h, expected %h", $time, o_thresh, thr_hist[0]);
        end
      if (o_valid) begin
        block_pending: assert (blocks_checked < exp_q.size())
          else begin
            value_errs++;
            $display("an output block appeared with no input block in flight");
          end
        if (blocks_checked < exp_q.size()) begin
          exp_blk = exp_q[blocks_checked];
          blocks_checked++;
          keep_check: assert (o_keep == exp_blk.keep)
            else begin
              value_errs++;
              $display("ERROR %0t: o_keep %h, expected %h", $time, o_keep, exp_blk.keep);
            end
          data_check: assert (o_data == exp_blk.data)
            else begin
              value_errs++;
              $display("ERROR %0t: o_data %h, expected %h", $time, o_data, exp_blk.data);
            end
          last_check: assert (o_last == exp_blk.last)
            else begin
              value_errs++;
              $display("ERROR %0t: o_last %b, expected %b", $time, o_last, exp_blk.last);
            end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    rst_n     <= 1'b0;
    i_ctrl    <= '0;
    i_data    <= '0;
    rnd_state = 32'd67497;
    model_thr = THR_INIT;
    frame_acc = 0;
    thr_hist  = {THR_INIT, THR_INIT, THR_INIT};
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_state: assert (!o_valid && !o_last && o_keep == '0 && o_data == '0
                         && o_thresh == THR_INIT)
      else begin
        flow_errs++;
        $display("ERROR %0t: outputs differ from their reset values", $time);
      end
    // first frame runs under THR_INIT so all lanes survive
    send_frame(16, SEL_REAL, 1'b0, 1'b0, 2);
    send_frame(16, SEL_REAL, 1'b0, 1'b0, 5);
    send_frame(16, SEL_CPLX, 1'b0, 1'b0, -1);
    send_frame(16, SEL_MIX, 1'b0, 1'b1, -1);
    send_frame(5, SEL_REAL, 1'b0, 1'b1, -1);
    // burst frame pushes the threshold into saturation
    send_frame(16, SEL_MIX, 1'b1, 1'b0, 3);
    send_frame(12, SEL_MIX, 1'b0, 1'b1, -1);
    send_frame(9, SEL_CPLX, 1'b0, 1'b1, 0);
    while (blocks_checked < exp_q.size()) begin
      drive_cycle('0, '0);
    end
    repeat (4) drive_cycle('0, '0);
    $display("blocks %0d, value errors %0d, latency errors %0d, flow errors %0d",
             blocks_checked, value_errs, latency_errs, flow_errs);
    if (value_errs + latency_errs + flow_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/excision_sample_pkg.sv
logic/excision_ctrl_pkg.sv
logic/magnitude_stage.sv
logic/threshold_estimator.sv
logic/threshold_compare.sv
logic/sample_align.sv
logic/blanking_stage.sv
logic/excision_top.sv
testbench/tb_excision.sv

// File: Makefile
# Verilator build and run of the excision testbench
VERILATOR ?= verilator
TOP       ?= tb_excision
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
